//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mips_id_ex_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/id_ex_if.sv
/* ID/EX pipeline register contents, decode to execute */
`timescale 1ns/1ps

interface id_ex_if;
	import mips_pkg::*;

	logic      valid;
	// execute controls
	logic      regdst;
	logic      alusrc;
	alu_op_t   aluop;
	// memory and writeback controls, passed through
	logic      branch;
	logic      memread;
	logic      memwrite;
	logic      memtoreg;
	logic      regwrite;
	// operands
	word_t     next_pc;
	word_t     data_rs;
	word_t     data_rt;
	word_t     sign_ext;
	reg_addr_t addr_rt;
	reg_addr_t addr_rd;

	modport producer (
		output valid, regdst, alusrc, aluop, branch, memread, memwrite, memtoreg,
		output regwrite, next_pc, data_rs, data_rt, sign_ext, addr_rt, addr_rd
	);

	modport consumer (
		input valid, regdst, alusrc, aluop, branch, memread, memwrite, memtoreg,
		input regwrite, next_pc, data_rs, data_rt, sign_ext, addr_rt, addr_rd
	);

endinterface

//--- common/mips_pkg.sv
/* shared MIPS types: data word, register number, opcode and funct fields,
   aluop classes and ALU operation encodings */
package mips_pkg;

	// ==============================
	// field and data widths
	// ==============================
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [1:0]  alu_op_t;
	typedef logic [3:0]  alu_ctrl_t;

	// ==============================
	// opcodes
	// ==============================
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_BEQ   = 6'h04;
	localparam opcode_t OP_ADDI  = 6'h08;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_SW    = 6'h2b;

	// R-type funct codes
	localparam funct_t FUNCT_SLL = 6'h00;
	localparam funct_t FUNCT_SRL = 6'h02;
	localparam funct_t FUNCT_ADD = 6'h20;
	localparam funct_t FUNCT_SUB = 6'h22;
	localparam funct_t FUNCT_AND = 6'h24;
	localparam funct_t FUNCT_OR  = 6'h25;
	localparam funct_t FUNCT_SLT = 6'h2a;

	// ==============================
	// ALU classes and operations
	// ==============================
	// memory access and addi
	localparam alu_op_t ALUOP_ADD   = 2'b00;
	// beq compare
	localparam alu_op_t ALUOP_SUB   = 2'b01;
	// decode from funct
	localparam alu_op_t ALUOP_FUNCT = 2'b10;

	localparam alu_ctrl_t ALU_AND = 4'b0000;
	localparam alu_ctrl_t ALU_OR  = 4'b0001;
	localparam alu_ctrl_t ALU_ADD = 4'b0010;
	localparam alu_ctrl_t ALU_SUB = 4'b0110;
	localparam alu_ctrl_t ALU_SLT = 4'b0111;
	localparam alu_ctrl_t ALU_SLL = 4'b1000;
	localparam alu_ctrl_t ALU_SRL = 4'b1001;

endpackage

//--- dv/mips_id_ex_properties.sv
/* concurrent checks on valid latency and control outputs, bound into the top level */
`timescale 1ns/1ps

module mips_id_ex_properties (
	input logic i_clk,
	input logic i_reset,
	input logic i_instr_valid,
	input logic o_ex_valid,
	input logic o_branch,
	input logic o_memread,
	input logic o_memwrite,
	input logic o_memtoreg,
	input logic o_regwrite
);

	logic any_ctrl;

	assign any_ctrl = o_branch | o_memread | o_memwrite | o_memtoreg | o_regwrite;

	// ==============================
	// pipeline latency
	// ==============================
	// both pipeline registers out of reset before the compare
	property valid_latency;
		@(posedge i_clk) disable iff (i_reset)
		(!$past(i_reset, 1) && !$past(i_reset, 2)) |-> (o_ex_valid == $past(i_instr_valid, 2));
	endproperty

	a_valid_latency: assert property (valid_latency)
	else
		$error("o_ex_valid does not follow i_instr_valid two cycles later");

	// ==============================
	// control outputs
	// ==============================
	property ctrl_needs_valid;
		@(posedge i_clk) disable iff (i_reset)
		!o_ex_valid |-> !any_ctrl;
	endproperty

	a_ctrl_needs_valid: assert property (ctrl_needs_valid)
	else
		$error("a control output is high while o_ex_valid is low");

	// first cycle out of reset
	property ctrl_low_after_reset;
		@(posedge i_clk)
		$fell(i_reset) |-> (!any_ctrl && !o_ex_valid);
	endproperty

	a_ctrl_low_after_reset: assert property (ctrl_low_after_reset)
	else
		$error("control outputs are not low in the cycle after reset");

endmodule

bind mips_id_ex mips_id_ex_properties u_properties (.*);

//--- dv/mips_id_ex_tb.sv
/* testbench for the decode and execute pipeline: stimulus, reference register
   model, expected-result queue and immediate assertions on the EX/MEM outputs */
`timescale 1ns/1ps

module mips_id_ex_tb;
	import mips_pkg::*;

	localparam int LEN_RESET     = 4;
	localparam int LEN_RTYPE     = 21;
	localparam int LEN_SHIFT_IMM = 9;
	localparam int LEN_BRANCH    = 4;
	localparam int LEN_STREAM    = 16;
	localparam int CYCLE_LIMIT   = LEN_RESET + LEN_RTYPE + LEN_SHIFT_IMM + LEN_BRANCH
		+ LEN_STREAM + 40;

	typedef struct packed {
		logic      valid;
		logic      check_data;
		logic      branch;
		logic      memread;
		logic      memwrite;
		logic      memtoreg;
		logic      regwrite;
		word_t     result;
		logic      zero;
		word_t     target;
		word_t     store;
		reg_addr_t dest;
	} expect_t;

	logic      i_clk;
	logic      i_reset;
	logic      i_instr_valid;
	word_t     i_instr;
	word_t     i_next_pc;
	logic      i_wb_en;
	reg_addr_t i_wb_addr;
	word_t     i_wb_data;
	logic      o_ex_valid;
	logic      o_branch;
	logic      o_memread;
	logic      o_memwrite;
	logic      o_memtoreg;
	logic      o_regwrite;
	word_t     o_branch_target;
	logic      o_zero;
	word_t     o_alu_result;
	word_t     o_store_data;
	reg_addr_t o_dest_addr;

	word_t       ref_regs [32];
	expect_t     exp_q [$];
	string       name_q [$];
	logic [31:0] lfsr_state;
	word_t       next_pc;
	int          errors;
	int          checks;
	int          cycle_count;

	mips_id_ex #(
		.P_RF_DEPTH (32)
	) dut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// run limit
	always @(posedge i_clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$finish;
		end
	end

	// ==============================
	// random numbers and encoding
	// ==============================
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// registers 1 to 8 hold the random operands
	function automatic reg_addr_t random_reg();
		return reg_addr_t'(take_bits(3)) + 5'd1;
	endfunction

	function automatic word_t encode_rtype(input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input logic [4:0] shamt, input funct_t funct);
		return {OP_RTYPE, rs, rt, rd, shamt, funct};
	endfunction

	function automatic word_t encode_itype(input opcode_t op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic funct_t alu_funct(input int kind);
		case (kind)
			0:       return FUNCT_ADD;
			1:       return FUNCT_SUB;
			2:       return FUNCT_AND;
			3:       return FUNCT_OR;
			default: return FUNCT_SLT;
		endcase
	endfunction

	// ==============================
	// reference model
	// ==============================
	// a write in the same cycle is visible to the read
	function automatic word_t read_ref(input reg_addr_t addr, input logic wb_en,
		input reg_addr_t wb_addr, input word_t wb_data);
		word_t value;
		value = ref_regs[addr];
		if (wb_en && (wb_addr == addr))
			value = wb_data;
		if (addr == '0)
			value = '0;
		return value;
	endfunction

	function automatic expect_t predict(input logic valid, input word_t instr,
		input word_t pc, input word_t rs_val, input word_t rt_val);
		expect_t    e;
		word_t      imm;
		logic [4:0] shamt;
		e = '0;
		imm = {{16{instr[15]}}, instr[15:0]};
		shamt = instr[10:6];
		e.valid = valid;
		e.target = pc + (imm << 2);
		e.store = rt_val;
		e.dest = instr[20:16];
		if (valid)
		begin
			case (opcode_t'(instr[31:26]))
				OP_RTYPE:
				begin
					e.regwrite = 1'b1;
					e.dest = instr[15:11];
					e.check_data = 1'b1;
					case (funct_t'(instr[5:0]))
						FUNCT_ADD: e.result = rs_val + rt_val;
						FUNCT_SUB: e.result = rs_val - rt_val;
						FUNCT_AND: e.result = rs_val & rt_val;
						FUNCT_OR:  e.result = rs_val | rt_val;
						FUNCT_SLT: e.result = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
						FUNCT_SLL: e.result = rt_val << shamt;
						FUNCT_SRL: e.result = rt_val >> shamt;
						default:   e.check_data = 1'b0;
					endcase
				end
				OP_ADDI:
				begin
					e.regwrite = 1'b1;
					e.result = rs_val + imm;
					e.check_data = 1'b1;
				end
				OP_LW:
				begin
					e.memread = 1'b1;
					e.memtoreg = 1'b1;
					e.regwrite = 1'b1;
					e.result = rs_val + imm;
					e.check_data = 1'b1;
				end
				OP_SW:
				begin
					e.memwrite = 1'b1;
					e.result = rs_val + imm;
					e.check_data = 1'b1;
				end
				OP_BEQ:
				begin
					e.branch = 1'b1;
					e.result = rs_val - rt_val;
					e.check_data = 1'b1;
				end
				// unknown opcode, controls stay low
				default: e.check_data = 1'b0;
			endcase
		end
		e.zero = (e.result == '0);
		return e;
	endfunction

	// ==============================
	// checks and stimulus
	// ==============================
	task automatic report_mismatch(input string test, input string field,
		input word_t expected, input word_t actual);
		$display("Error %s %s: expected %h, actual %h", test, field, expected, actual);
		errors++;
	endtask

	task automatic compare_head();
		expect_t    e;
		string      name;
		logic [4:0] exp_ctrl;
		logic [4:0] act_ctrl;
		e = exp_q.pop_front();
		name = name_q.pop_front();
		exp_ctrl = {e.branch, e.memread, e.memwrite, e.memtoreg, e.regwrite};
		act_ctrl = {o_branch, o_memread, o_memwrite, o_memtoreg, o_regwrite};
		checks++;
		assert (o_ex_valid === e.valid)
		else
			report_mismatch(name, "valid", 32'(e.valid), 32'(o_ex_valid));
		assert (act_ctrl === exp_ctrl)
		else
			report_mismatch(name, "controls", 32'(exp_ctrl), 32'(act_ctrl));
		if (e.valid && e.check_data)
		begin
			assert (o_alu_result === e.result)
			else
				report_mismatch(name, "result", e.result, o_alu_result);
			assert (o_zero === e.zero)
			else
				report_mismatch(name, "zero", 32'(e.zero), 32'(o_zero));
			assert (o_branch_target === e.target)
			else
				report_mismatch(name, "target", e.target, o_branch_target);
			assert (o_store_data === e.store)
			else
				report_mismatch(name, "store data", e.store, o_store_data);
			assert (o_dest_addr === e.dest)
			else
				report_mismatch(name, "destination", 32'(e.dest), 32'(o_dest_addr));
		end
	endtask

	// one cycle: check the result due now, then drive the next inputs
	task automatic issue(input string name, input logic valid, input word_t instr,
		input logic wb_en, input reg_addr_t wb_addr, input word_t wb_data);
		word_t rs_val;
		word_t rt_val;
		if (exp_q.size() == 2)
			compare_head();
		rs_val = read_ref(instr[25:21], wb_en, wb_addr, wb_data);
		rt_val = read_ref(instr[20:16], wb_en, wb_addr, wb_data);
		i_instr_valid = valid;
		i_instr = instr;
		i_next_pc = next_pc;
		i_wb_en = wb_en;
		i_wb_addr = wb_addr;
		i_wb_data = wb_data;
		exp_q.push_back(predict(valid, instr, next_pc, rs_val, rt_val));
		name_q.push_back(name);
		if (wb_en && (wb_addr != '0))
			ref_regs[wb_addr] = wb_data;
		next_pc = next_pc + 32'd4;
		@(posedge i_clk);
		#1;
	endtask

	task automatic run_instr(input string name, input word_t instr);
		issue(name, 1'b1, instr, 1'b0, '0, '0);
	endtask

	task automatic write_reg(input string name, input reg_addr_t addr, input word_t data);
		issue(name, 1'b0, '0, 1'b1, addr, data);
	endtask

	initial
	begin
		word_t instr;
		int    kind;
		i_reset = 1'b1;
		i_instr_valid = 1'b0;
		i_instr = '0;
		i_next_pc = '0;
		i_wb_en = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		lfsr_state = 32'hcf8d_5b5b;
		next_pc = 32'h0040_0004;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		for (int r = 0; r < 32; r++)
			ref_regs[r] = '0;
		repeat (3) @(posedge i_clk);
		#1;
		i_reset = 1'b0;

		repeat (LEN_RESET) issue("reset_bubble", 1'b0, '0, 1'b0, '0, '0);

		for (int r = 1; r <= 8; r++)
			write_reg("rtype_setup", reg_addr_t'(r), take_bits(32));
		for (int i = 0; i < 10; i++)
			run_instr("rtype", encode_rtype(random_reg(), random_reg(), reg_addr_t'(10 + i),
				5'd0, alu_funct(i % 5)));
		issue("rtype_bypass", 1'b1, encode_rtype(5'd3, 5'd4, 5'd12, 5'd0, FUNCT_SUB),
			1'b1, 5'd3, take_bits(32));
		issue("rtype_zero", 1'b1, encode_rtype(5'd0, 5'd5, 5'd13, 5'd0, FUNCT_OR),
			1'b1, 5'd0, 32'hffff_ffff);
		run_instr("rtype_zero", encode_rtype(5'd0, 5'd0, 5'd14, 5'd0, FUNCT_ADD));

		for (int i = 0; i < 2; i++)
		begin
			run_instr("shift_imm", encode_rtype(5'd0, random_reg(), 5'd15, 5'(take_bits(5)),
				FUNCT_SLL));
			run_instr("shift_imm", encode_rtype(5'd0, random_reg(), 5'd16, 5'(take_bits(5)),
				FUNCT_SRL));
		end
		run_instr("shift_imm", encode_itype(OP_ADDI, random_reg(), 5'd17, 16'hfff0));
		run_instr("shift_imm", encode_itype(OP_ADDI, random_reg(), 5'd18, 16'h8000));
		run_instr("shift_imm", encode_itype(OP_ADDI, random_reg(), 5'd19, 16'(take_bits(16))));
		run_instr("shift_imm", encode_itype(OP_LW, random_reg(), 5'd20, 16'(take_bits(16))));
		run_instr("shift_imm", encode_itype(OP_SW, random_reg(), random_reg(),
			16'(take_bits(16))));

		run_instr("branch", encode_itype(OP_BEQ, 5'd5, 5'd5, 16'(take_bits(16))));
		run_instr("branch", encode_itype(OP_BEQ, 5'd5, 5'd6, 16'hfffc));
		write_reg("branch_setup", 5'd7, ref_regs[6]);
		run_instr("branch", encode_itype(OP_BEQ, 5'd6, 5'd7, 16'(take_bits(16))));

		// back-to-back mix with two unknown opcodes
		for (int i = 0; i < LEN_STREAM; i++)
		begin
			kind = int'(take_bits(3));
			if ((i == 5) || (i == 11))
				instr = encode_itype(6'h3f, random_reg(), random_reg(), 16'(take_bits(16)));
			else if (kind < 5)
				instr = encode_rtype(random_reg(), random_reg(), reg_addr_t'(take_bits(5)),
					5'd0, alu_funct(kind));
			else if (kind == 5)
				instr = encode_rtype(5'd0, random_reg(), random_reg(), 5'(take_bits(5)),
					FUNCT_SRL);
			else if (kind == 6)
				instr = encode_itype(OP_ADDI, random_reg(), random_reg(), 16'(take_bits(16)));
			else
				instr = encode_itype(OP_BEQ, random_reg(), random_reg(), 16'(take_bits(16)));
			run_instr("throughput", instr);
		end

		i_instr_valid = 1'b0;
		i_wb_en = 1'b0;
		while (exp_q.size() > 0)
		begin
			compare_head();
			if (exp_q.size() > 0)
			begin
				@(posedge i_clk);
				#1;
			end
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- filelist.f
common/mips_pkg.sv
common/id_ex_if.sv
rtl/decode/decode_control.sv
rtl/decode/register_file.sv
rtl/decode/decode_stage.sv
rtl/execute/alu_control.sv
rtl/execute/alu.sv
rtl/execute/execute_stage.sv
rtl/mips_id_ex.sv
dv/mips_id_ex_properties.sv
dv/mips_id_ex_tb.sv

//--- rtl/decode/decode_control.sv
/* main control unit, opcode to pipeline control bits */
`timescale 1ns/1ps

module decode_control (
	input  mips_pkg::opcode_t i_opcode,
	output logic              o_regdst,
	output logic              o_alusrc,
	output logic              o_branch,
	output logic              o_memread,
	output logic              o_memwrite,
	output logic              o_memtoreg,
	output logic              o_regwrite,
	output mips_pkg::alu_op_t o_aluop
);
	import mips_pkg::*;

	always_comb
	begin
		// unknown opcodes fall through as a bubble
		o_regdst   = 1'b0;
		o_alusrc   = 1'b0;
		o_branch   = 1'b0;
		o_memread  = 1'b0;
		o_memwrite = 1'b0;
		o_memtoreg = 1'b0;
		o_regwrite = 1'b0;
		o_aluop    = ALUOP_ADD;
		case (i_opcode)
			OP_RTYPE:
			begin
				o_regdst   = 1'b1;
				o_regwrite = 1'b1;
				o_aluop    = ALUOP_FUNCT;
			end
			OP_ADDI:
			begin
				// I-type add, rt is the target
				o_alusrc   = 1'b1;
				o_regwrite = 1'b1;
			end
			OP_LW:
			begin
				o_alusrc   = 1'b1;
				o_memread  = 1'b1;
				o_memtoreg = 1'b1;
				o_regwrite = 1'b1;
			end
			OP_SW:
			begin
				o_alusrc   = 1'b1;
				o_memwrite = 1'b1;
			end
			OP_BEQ:
			begin
				o_branch = 1'b1;
				o_aluop  = ALUOP_SUB;
			end
			default:
			begin
				o_aluop = ALUOP_ADD;
			end
		endcase
	end

endmodule

//--- rtl/decode/decode_stage.sv
/* decode stage: field split, operand read, sign extension, ID/EX register */
`timescale 1ns/1ps

module decode_stage #(
	parameter int P_RF_DEPTH = 32
) (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_instr_valid,
	input  mips_pkg::word_t     i_instr,
	input  mips_pkg::word_t     i_next_pc,
	input  logic                i_wb_en,
	input  mips_pkg::reg_addr_t i_wb_addr,
	input  mips_pkg::word_t     i_wb_data,
	id_ex_if.producer           o_id_ex
);
	import mips_pkg::*;

	// ==============================
	// instruction fields
	// ==============================
	opcode_t   opcode;
	reg_addr_t addr_rs;
	reg_addr_t addr_rt;
	reg_addr_t addr_rd;
	word_t     sign_ext;
	word_t     rs_data;
	word_t     rt_data;

	logic    regdst;
	logic    alusrc;
	logic    branch;
	logic    memread;
	logic    memwrite;
	logic    memtoreg;
	logic    regwrite;
	alu_op_t aluop;

	assign opcode   = i_instr[31:26];
	assign addr_rs  = i_instr[25:21];
	assign addr_rt  = i_instr[20:16];
	assign addr_rd  = i_instr[15:11];
	assign sign_ext = {{16{i_instr[15]}}, i_instr[15:0]};

	decode_control u_control (
		.i_opcode   (opcode),
		.o_regdst   (regdst),
		.o_alusrc   (alusrc),
		.o_branch   (branch),
		.o_memread  (memread),
		.o_memwrite (memwrite),
		.o_memtoreg (memtoreg),
		.o_regwrite (regwrite),
		.o_aluop    (aluop)
	);

	register_file #(
		.P_RF_DEPTH (P_RF_DEPTH)
	) u_regfile (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_rs_addr (addr_rs),
		.i_rt_addr (addr_rt),
		.i_wb_en   (i_wb_en),
		.i_wb_addr (i_wb_addr),
		.i_wb_data (i_wb_data),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	// ==============================
	// ID/EX register
	// ==============================
	// controls, a missing instruction loads a bubble
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_id_ex.valid    <= 1'b0;
			o_id_ex.regdst   <= 1'b0;
			o_id_ex.alusrc   <= 1'b0;
			o_id_ex.aluop    <= ALUOP_ADD;
			o_id_ex.branch   <= 1'b0;
			o_id_ex.memread  <= 1'b0;
			o_id_ex.memwrite <= 1'b0;
			o_id_ex.memtoreg <= 1'b0;
			o_id_ex.regwrite <= 1'b0;
		end
		else
		begin
			o_id_ex.valid    <= i_instr_valid;
			o_id_ex.regdst   <= i_instr_valid & regdst;
			o_id_ex.alusrc   <= i_instr_valid & alusrc;
			o_id_ex.aluop    <= i_instr_valid ? aluop : ALUOP_ADD;
			o_id_ex.branch   <= i_instr_valid & branch;
			o_id_ex.memread  <= i_instr_valid & memread;
			o_id_ex.memwrite <= i_instr_valid & memwrite;
			o_id_ex.memtoreg <= i_instr_valid & memtoreg;
			o_id_ex.regwrite <= i_instr_valid & regwrite;
		end
	end

	// operands and fields
	always_ff @(posedge i_clk)
	begin
		o_id_ex.next_pc  <= i_next_pc;
		o_id_ex.data_rs  <= rs_data;
		o_id_ex.data_rt  <= rt_data;
		o_id_ex.sign_ext <= sign_ext;
		o_id_ex.addr_rt  <= addr_rt;
		o_id_ex.addr_rd  <= addr_rd;
	end

endmodule

//--- rtl/decode/register_file.sv
/* two-read one-write register file, register zero tied low, write-through bypass */
`timescale 1ns/1ps

module register_file #(
	parameter int P_RF_DEPTH = 32
) (
	input  logic                i_clk,
	input  logic                i_reset,
	input  mips_pkg::reg_addr_t i_rs_addr,
	input  mips_pkg::reg_addr_t i_rt_addr,
	input  logic                i_wb_en,
	input  mips_pkg::reg_addr_t i_wb_addr,
	input  mips_pkg::word_t     i_wb_data,
	output mips_pkg::word_t     o_rs_data,
	output mips_pkg::word_t     o_rt_data
);
	import mips_pkg::*;

	word_t regs [P_RF_DEPTH];
	logic  wr_ok;

	// zero register and numbers past the depth are not stored
	assign wr_ok = i_wb_en && (i_wb_addr != '0) && (int'(i_wb_addr) < P_RF_DEPTH);

	function automatic word_t read_port(input reg_addr_t addr);
		word_t data;
		data = '0;
		if ((addr != '0) && (int'(addr) < P_RF_DEPTH))
		begin
			if (wr_ok && (addr == i_wb_addr))
				data = i_wb_data;
			else
				data = regs[int'(addr)];
		end
		return data;
	endfunction

	// reads follow the storage and the write port as well as the address
	always_comb
	begin
		o_rs_data = read_port(i_rs_addr);
		o_rt_data = read_port(i_rt_addr);
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			for (int i = 0; i < P_RF_DEPTH; i++)
				regs[i] <= '0;
		end
		else if (wr_ok)
		begin
			regs[int'(i_wb_addr)] <= i_wb_data;
		end
	end

endmodule

//--- rtl/execute/alu.sv
/* combinational ALU with zero flag and shamt shifts */
`timescale 1ns/1ps

module alu (
	input  mips_pkg::word_t     i_a,
	input  mips_pkg::word_t     i_b,
	input  logic [4:0]          i_shamt,
	input  mips_pkg::alu_ctrl_t i_alu_ctrl,
	output mips_pkg::word_t     o_result,
	output logic                o_zero
);
	import mips_pkg::*;

	logic less;

	// signed compare for slt
	assign less = $signed(i_a) < $signed(i_b);

	always_comb
	begin
		case (i_alu_ctrl)
			ALU_AND:
				o_result = i_a & i_b;
			ALU_OR:
				o_result = i_a | i_b;
			ALU_ADD:
				o_result = i_a + i_b;
			ALU_SUB:
				o_result = i_a - i_b;
			ALU_SLT:
				o_result = {31'b0, less};
			// shifts move the B operand, rt for R-type
			ALU_SLL:
				o_result = i_b << i_shamt;
			ALU_SRL:
				o_result = i_b >> i_shamt;
			default:
				o_result = '0;
		endcase
	end

	assign o_zero = (o_result == '0);

endmodule

//--- rtl/execute/alu_control.sv
/* ALU operation decode from aluop and funct */
`timescale 1ns/1ps

module alu_control (
	input  mips_pkg::alu_op_t   i_aluop,
	input  mips_pkg::funct_t    i_funct,
	output mips_pkg::alu_ctrl_t o_alu_ctrl
);
	import mips_pkg::*;

	alu_ctrl_t funct_ctrl;

	// R-type operation, unknown funct falls back to add
	always_comb
	begin
		case (i_funct)
			FUNCT_ADD: funct_ctrl = ALU_ADD;
			FUNCT_SUB: funct_ctrl = ALU_SUB;
			FUNCT_AND: funct_ctrl = ALU_AND;
			FUNCT_OR:  funct_ctrl = ALU_OR;
			FUNCT_SLT: funct_ctrl = ALU_SLT;
			FUNCT_SLL: funct_ctrl = ALU_SLL;
			FUNCT_SRL: funct_ctrl = ALU_SRL;
			default:   funct_ctrl = ALU_ADD;
		endcase
	end

	always_comb
	begin
		case (i_aluop)
			ALUOP_ADD:   o_alu_ctrl = ALU_ADD;
			ALUOP_SUB:   o_alu_ctrl = ALU_SUB;
			ALUOP_FUNCT: o_alu_ctrl = funct_ctrl;
			default:     o_alu_ctrl = ALU_ADD;
		endcase
	end

endmodule

//--- rtl/execute/execute_stage.sv
/* execute stage: branch adder, operand and destination select, EX/MEM register */
`timescale 1ns/1ps

module execute_stage (
	input  logic                i_clk,
	input  logic                i_reset,
	id_ex_if.consumer           i_id_ex,
	output logic                o_ex_valid,
	output logic                o_branch,
	output logic                o_memread,
	output logic                o_memwrite,
	output logic                o_memtoreg,
	output logic                o_regwrite,
	output mips_pkg::word_t     o_branch_target,
	output logic                o_zero,
	output mips_pkg::word_t     o_alu_result,
	output mips_pkg::word_t     o_store_data,
	output mips_pkg::reg_addr_t o_dest_addr
);
	import mips_pkg::*;

	word_t     branch_target;
	word_t     alu_b;
	word_t     alu_result;
	logic      alu_zero;
	alu_ctrl_t alu_ctrl;
	reg_addr_t dest_addr;

	// PC+4 plus word offset
	assign branch_target = i_id_ex.next_pc + {i_id_ex.sign_ext[29:0], 2'b00};
	assign alu_b         = i_id_ex.alusrc ? i_id_ex.sign_ext : i_id_ex.data_rt;
	assign dest_addr     = i_id_ex.regdst ? i_id_ex.addr_rd : i_id_ex.addr_rt;

	// funct and shamt live in the low immediate bits
	alu_control u_alu_control (
		.i_aluop    (i_id_ex.aluop),
		.i_funct    (i_id_ex.sign_ext[5:0]),
		.o_alu_ctrl (alu_ctrl)
	);

	alu u_alu (
		.i_a        (i_id_ex.data_rs),
		.i_b        (alu_b),
		.i_shamt    (i_id_ex.sign_ext[10:6]),
		.i_alu_ctrl (alu_ctrl),
		.o_result   (alu_result),
		.o_zero     (alu_zero)
	);

	// ==============================
	// EX/MEM register
	// ==============================
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_ex_valid <= 1'b0;
			o_branch   <= 1'b0;
			o_memread  <= 1'b0;
			o_memwrite <= 1'b0;
			o_memtoreg <= 1'b0;
			o_regwrite <= 1'b0;
		end
		else
		begin
			o_ex_valid <= i_id_ex.valid;
			o_branch   <= i_id_ex.branch;
			o_memread  <= i_id_ex.memread;
			o_memwrite <= i_id_ex.memwrite;
			o_memtoreg <= i_id_ex.memtoreg;
			o_regwrite <= i_id_ex.regwrite;
		end
	end

	always_ff @(posedge i_clk)
	begin
		o_branch_target <= branch_target;
		o_zero          <= alu_zero;
		o_alu_result    <= alu_result;
		o_store_data    <= i_id_ex.data_rt;
		o_dest_addr     <= dest_addr;
	end

endmodule

//--- rtl/mips_id_ex.sv
/* decode and execute pipeline top level */
`timescale 1ns/1ps

module mips_id_ex #(
	parameter int P_RF_DEPTH = 32
) (
	input  logic                i_clk,
	input  logic                i_reset,
	// instruction in
	input  logic                i_instr_valid,
	input  mips_pkg::word_t     i_instr,
	input  mips_pkg::word_t     i_next_pc,
	// writeback port
	input  logic                i_wb_en,
	input  mips_pkg::reg_addr_t i_wb_addr,
	input  mips_pkg::word_t     i_wb_data,
	// EX/MEM outputs
	output logic                o_ex_valid,
	output logic                o_branch,
	output logic                o_memread,
	output logic                o_memwrite,
	output logic                o_memtoreg,
	output logic                o_regwrite,
	output mips_pkg::word_t     o_branch_target,
	output logic                o_zero,
	output mips_pkg::word_t     o_alu_result,
	output mips_pkg::word_t     o_store_data,
	output mips_pkg::reg_addr_t o_dest_addr
);

	id_ex_if id_ex ();

	decode_stage #(
		.P_RF_DEPTH (P_RF_DEPTH)
	) u_decode (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_next_pc     (i_next_pc),
		.i_wb_en       (i_wb_en),
		.i_wb_addr     (i_wb_addr),
		.i_wb_data     (i_wb_data),
		.o_id_ex       (id_ex.producer)
	);

	execute_stage u_execute (
		.i_clk           (i_clk),
		.i_reset         (i_reset),
		.i_id_ex         (id_ex.consumer),
		.o_ex_valid      (o_ex_valid),
		.o_branch        (o_branch),
		.o_memread       (o_memread),
		.o_memwrite      (o_memwrite),
		.o_memtoreg      (o_memtoreg),
		.o_regwrite      (o_regwrite),
		.o_branch_target (o_branch_target),
		.o_zero          (o_zero),
		.o_alu_result    (o_alu_result),
		.o_store_data    (o_store_data),
		.o_dest_addr     (o_dest_addr)
	);

endmodule
